// ==== pipeline.sv ====
`default_nettype none

// generic delay line
// output follows the input DEPTH clock edges later
// DEPTH of 0 gives a plain wire
module pipeline #(
  parameter type data_t = logic,
  parameter int  DEPTH  = 1
) (
  input  wire   clk_i,
  input  wire   arst_n_i,
  input  wire   data_t data_i,
  output data_t data_o
);

  generate
    if (DEPTH == 0) begin : g_wire
      // no stages, pass straight through
      assign data_o = data_i;
    end else begin : g_regs
      // stage_q[0] is the input side
      data_t stage_q [DEPTH];

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          // every stage clears to zero
          for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
          end
        end else begin
          stage_q[0] <= data_i;
          // shift one stage per edge
          for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
          end
        end
      end

      // last stage drives the output
      assign data_o = stage_q[DEPTH-1];
    end
  endgenerate

endmodule : pipeline

`default_nettype wire

// ==== ppu_control_unit.sv ====
`default_nettype none

// issue control of the ppu
// forms accept, delays valid and the accumulator write flag,
// and holds back ACC while an accumulator writer is in flight
module ppu_control_unit (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  valid_i,
  input  wire ppu_pkg::operation_e op_i,
  output logic                 accept_o,
  output logic                 valid_o,
  output logic                 acc_we_o,
  output logic                 stall_o
);

  // op writes the accumulator when it retires
  logic acc_writer;
  // accepted accumulator writer this cycle
  logic acc_issue;
  // writers between issue and write back
  logic [ppu_pkg::CNT_W-1:0] inflight_q;

  assign acc_writer = (op_i == ppu_pkg::OP_ACC) || (op_i == ppu_pkg::OP_CLR);

  // ACC must see the accumulator after every older write
  // CLR ignores the old value so it never waits
  assign stall_o = valid_i && (op_i == ppu_pkg::OP_ACC) && (inflight_q != '0);

  assign accept_o  = valid_i && !stall_o;
  assign acc_issue = accept_o && acc_writer;

  // valid travels with the result
  pipeline #(
    .data_t (logic),
    .DEPTH  (ppu_pkg::PIPE_DEPTH)
  ) valid_signal_delay (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (accept_o),
    .data_o   (valid_o)
  );

  // write flag retires with its own result
  pipeline #(
    .data_t (logic),
    .DEPTH  (ppu_pkg::PIPE_DEPTH)
  ) acc_write_delay (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (acc_issue),
    .data_o   (acc_we_o)
  );

  // up on issue, down on write back, both may hit one edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
    end else begin
      case ({acc_issue, acc_we_o})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // a write back always has a matching issue counted earlier
  a_cnt_no_underflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    acc_we_o |-> (inflight_q != '0)
  );

  // at most one writer per pipeline stage
  a_cnt_bounded : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    inflight_q <= ppu_pkg::CNT_W'(ppu_pkg::PIPE_DEPTH)
  );

  // no ACC taken until the older writer has retired
  a_acc_no_hazard : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    acc_issue |=> (!(accept_o && (op_i == ppu_pkg::OP_ACC))) [*ppu_pkg::PIPE_DEPTH]
  );

endmodule : ppu_control_unit

`default_nettype wire

// ==== ppu_datapath.sv ====
`default_nettype none

// ppu datapath
// result is formed at issue and carried down the delay line,
// the accumulator takes the retiring ACC or CLR result
module ppu_datapath (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  accept_i,
  input  wire                  acc_we_i,
  input  wire ppu_pkg::operation_e op_i,
  input  wire ppu_pkg::operand_t   a_i,
  input  wire ppu_pkg::operand_t   b_i,
  output ppu_pkg::result_t     result_o
);

  // operands widened to result width
  ppu_pkg::result_t a_ext;
  ppu_pkg::result_t b_ext;
  // full product, 16 x 16 never overflows 32
  ppu_pkg::result_t product;
  // value computed at issue
  ppu_pkg::result_t issue_res;
  // what enters the delay line
  ppu_pkg::result_t stage_in;
  ppu_pkg::result_t acc_q;
  // shadow of accept, msb marks a result due now
  logic [ppu_pkg::PIPE_DEPTH-1:0] due_q;

  assign a_ext   = ppu_pkg::RES_W'(a_i);
  assign b_ext   = ppu_pkg::RES_W'(b_i);
  assign product = a_ext * b_ext;

  // add and sub wrap modulo 2^32
  always_comb begin
    case (op_i)
      ppu_pkg::OP_ADD: issue_res = a_ext + b_ext;
      ppu_pkg::OP_SUB: issue_res = a_ext - b_ext;
      ppu_pkg::OP_MUL: issue_res = product;
      ppu_pkg::OP_ACC: issue_res = acc_q + product;
      // CLR and unused codes give zero
      default:         issue_res = '0;
    endcase
  end

  // idle slots carry zero
  assign stage_in = accept_i ? issue_res : '0;

  pipeline #(
    .data_t (ppu_pkg::result_t),
    .DEPTH  (ppu_pkg::PIPE_DEPTH)
  ) result_delay (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (stage_in),
    .data_o   (result_o)
  );

  // write back of ACC sum or CLR zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (acc_we_i) begin
      acc_q <= result_o;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      due_q <= '0;
    end else begin
      due_q <= {due_q[ppu_pkg::PIPE_DEPTH-2:0], accept_i};
    end
  end

  // no stale payload leaks out between results
  a_idle_result_zero : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !due_q[ppu_pkg::PIPE_DEPTH-1] |-> (result_o == '0)
  );

endmodule : ppu_datapath

`default_nettype wire

// ==== ppu_pkg.sv ====
`default_nettype none

// shared widths, depths and types of the ppu
package ppu_pkg;

  // operand width
  localparam int DATA_W = 16;

  // result and accumulator width
  localparam int RES_W = 32;

  // stages in each half of the unit
  localparam int INNER_PIPELINE_DEPTH = 2;

  // issue to result latency in cycles
  localparam int PIPE_DEPTH = INNER_PIPELINE_DEPTH * 2;

  // in-flight writer count, 0 up to PIPE_DEPTH inclusive
  localparam int CNT_W = $clog2(PIPE_DEPTH + 1);

  // operation codes
  // ACC reads and writes the accumulator, CLR only writes it
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_MUL = 3'd2,
    OP_ACC = 3'd3,
    OP_CLR = 3'd4
  } operation_e;

  // unsigned operand
  typedef logic [DATA_W-1:0] operand_t;

  // result, also the accumulator payload
  typedef logic [RES_W-1:0] result_t;

endpackage : ppu_pkg

`default_nettype wire

// ==== ppu_tb.sv ====
`default_nettype none

// self-checking testbench of the ppu
// table driven directed rows, then seeded random ops
module ppu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 10;
  localparam int NUM_ROWS    = 15;
  localparam int NUM_RANDOM  = 200;
  // cycles any single wait may take
  localparam int WAIT_LIMIT  = 50;

  logic                clk_i;
  logic                arst_n_i;
  logic                valid_i;
  ppu_pkg::operation_e op_i;
  ppu_pkg::operand_t   a_i;
  ppu_pkg::operand_t   b_i;
  logic                stall_o;
  logic                valid_o;
  ppu_pkg::result_t    result_o;

  // stimulus table with expected result and expected stall at first drive
  ppu_pkg::operation_e tbl_op    [NUM_ROWS];
  ppu_pkg::operand_t   tbl_a     [NUM_ROWS];
  ppu_pkg::operand_t   tbl_b     [NUM_ROWS];
  ppu_pkg::result_t    tbl_exp   [NUM_ROWS];
  logic                tbl_stall [NUM_ROWS];

  // outstanding results and their issue cycles, in issue order
  ppu_pkg::result_t exp_q  [$];
  int               edge_q [$];

  // accumulator as the model sees it
  ppu_pkg::result_t acc_model;
  int               seed;
  // posedges since time zero
  int               cyc;
  int               errors;
  int               checks;
  int               issued;
  int               received;
  int               tests_run;
  int               tests_failed;
  logic             timed_out;

  ppu_top u_dut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .stall_o  (stall_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  // 20 ns clock
  always #(HALF_PERIOD) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic check_result(input string name, input ppu_pkg::result_t got,
                              input ppu_pkg::result_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (arst_n_i && valid_o) begin
      if (exp_q.size() == 0) begin
        $display("result 0x%08h at %0t ns arrived with no operation outstanding",
                 result_o, $time);
        errors++;
      end else begin
        check_result("result_o", result_o, exp_q.pop_front());
        check_latency("latency", cyc - edge_q.pop_front(), ppu_pkg::PIPE_DEPTH);
      end
      received++;
    end
  end

  // expected values follow the operation rules, accumulator in issue order
  function automatic ppu_pkg::result_t model_result(input ppu_pkg::operation_e op,
                                                    input ppu_pkg::operand_t a,
                                                    input ppu_pkg::operand_t b);
    ppu_pkg::result_t wa;
    ppu_pkg::result_t wb;
    wa = ppu_pkg::RES_W'(a);
    wb = ppu_pkg::RES_W'(b);
    case (op)
      ppu_pkg::OP_ADD: return wa + wb;
      ppu_pkg::OP_SUB: return wa - wb;
      ppu_pkg::OP_MUL: return wa * wb;
      ppu_pkg::OP_ACC: return acc_model + wa * wb;
      default:         return '0;
    endcase
  endfunction

  task automatic set_row(input int idx, input ppu_pkg::operation_e op,
                         input ppu_pkg::operand_t a, input ppu_pkg::operand_t b,
                         input ppu_pkg::result_t exp, input logic stl);
    tbl_op[idx]    = op;
    tbl_a[idx]     = a;
    tbl_b[idx]     = b;
    tbl_exp[idx]   = exp;
    tbl_stall[idx] = stl;
  endtask

  task automatic load_table();
    // plain arithmetic, back to back
    set_row(0,  ppu_pkg::OP_ADD, 16'h0003, 16'h0004, 32'h0000_0007, 1'b0);
    set_row(1,  ppu_pkg::OP_ADD, 16'hFFFF, 16'hFFFF, 32'h0001_FFFE, 1'b0);
    set_row(2,  ppu_pkg::OP_SUB, 16'h0010, 16'h0003, 32'h0000_000D, 1'b0);
    // wraps below zero
    set_row(3,  ppu_pkg::OP_SUB, 16'h0001, 16'h0002, 32'hFFFF_FFFF, 1'b0);
    set_row(4,  ppu_pkg::OP_MUL, 16'h0012, 16'h0034, 32'h0000_03A8, 1'b0);
    set_row(5,  ppu_pkg::OP_MUL, 16'hFFFF, 16'hFFFF, 32'hFFFE_0001, 1'b0);
    set_row(6,  ppu_pkg::OP_SUB, 16'h0000, 16'hFFFF, 32'hFFFF_0001, 1'b0);
    // every ACC here waits on the writer before it
    set_row(7,  ppu_pkg::OP_CLR, 16'h0000, 16'h0000, 32'h0000_0000, 1'b0);
    set_row(8,  ppu_pkg::OP_ACC, 16'h0002, 16'h0003, 32'h0000_0006, 1'b1);
    set_row(9,  ppu_pkg::OP_ACC, 16'h0004, 16'h0005, 32'h0000_001A, 1'b1);
    set_row(10, ppu_pkg::OP_ACC, 16'h0100, 16'h0100, 32'h0001_001A, 1'b1);
    set_row(11, ppu_pkg::OP_ACC, 16'hFFFF, 16'hFFFF, 32'hFFFF_001B, 1'b1);
    // clear, then a single product
    set_row(12, ppu_pkg::OP_CLR, 16'h0007, 16'h0009, 32'h0000_0000, 1'b0);
    set_row(13, ppu_pkg::OP_ACC, 16'h0007, 16'h0009, 32'h0000_003F, 1'b1);
    set_row(14, ppu_pkg::OP_ADD, 16'h0001, 16'h0001, 32'h0000_0002, 1'b0);
  endtask

  // drive at the falling edge, returns at the falling edge after acceptance
  task automatic issue_op(input ppu_pkg::operation_e op, input ppu_pkg::operand_t a,
                          input ppu_pkg::operand_t b, input ppu_pkg::result_t exp,
                          input logic chk_stall, input logic exp_stall);
    int waited;
    if (timed_out) return;
    valid_i = 1'b1;
    op_i    = op;
    a_i     = a;
    b_i     = b;
    // stall_o settles well before the rising edge
    #(HALF_PERIOD / 2);
    if (chk_stall) check_flag("stall_o", stall_o, exp_stall);
    waited = 0;
    // inputs held while stalled
    while (stall_o && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      #(HALF_PERIOD / 2);
      waited++;
    end
    if (stall_o) begin
      $display("stall_o stayed high for %0d cycles at %0t ns", WAIT_LIMIT, $time);
      timed_out = 1'b1;
    end else begin
      exp_q.push_back(exp);
      // cycle the op is presented in, taken at the coming rising edge
      edge_q.push_back(cyc);
      issued++;
      if (op == ppu_pkg::OP_ACC || op == ppu_pkg::OP_CLR) acc_model = exp;
      @(negedge clk_i);
    end
  endtask

  // rising edge polling keeps clear of the monitor
  task automatic wait_drain(input string name);
    int waited;
    if (timed_out) return;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d results of test %s never arrived", exp_q.size(), name);
      timed_out = 1'b1;
    end
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (errors == start_err && !timed_out) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - start_err);
    end
  endtask

  task automatic run_rows(input string name, input int first, input int last);
    int start_err;
    start_err = errors;
    for (int i = first; i <= last; i++) begin
      issue_op(tbl_op[i], tbl_a[i], tbl_b[i], tbl_exp[i], 1'b1, tbl_stall[i]);
    end
    valid_i = 1'b0;
    wait_drain(name);
    report_test(name, start_err);
  endtask

  task automatic run_random();
    int start_err;
    int r;
    ppu_pkg::operation_e op;
    ppu_pkg::operand_t a;
    ppu_pkg::operand_t b;
    start_err = errors;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r  = $random(seed);
      op = ppu_pkg::operation_e'(3'($unsigned(r) % 5));
      a  = ppu_pkg::DATA_W'($random(seed));
      b  = ppu_pkg::DATA_W'($random(seed));
      // idle slot now and then
      if (r[7:5] == 3'd0) begin
        valid_i = 1'b0;
        @(negedge clk_i);
      end
      issue_op(op, a, b, model_result(op, a, b), 1'b0, 1'b0);
    end
    valid_i = 1'b0;
    wait_drain("random");
    // each accepted op gives exactly one result
    checks++;
    if (received != issued) begin
      $display("ERROR at %0t ns: results received got %0d expected %0d",
               $time, received, issued);
      errors++;
    end
    report_test("random", start_err);
  endtask

  initial begin
    int start_err;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    valid_i      = 1'b0;
    op_i         = ppu_pkg::OP_ADD;
    a_i          = '0;
    b_i          = '0;
    acc_model    = '0;
    seed         = 36329;
    cyc          = 0;
    errors       = 0;
    checks       = 0;
    issued       = 0;
    received     = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    load_table();

    // 5 cycles in reset
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;

    // quiet outputs until the first op
    start_err = errors;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("valid_o", valid_o, 1'b0);
      check_flag("stall_o", stall_o, 1'b0);
      check_result("result_o", result_o, '0);
    end
    report_test("reset state", start_err);

    run_rows("arithmetic back to back", 0, 6);
    run_rows("acc chain", 7, 11);
    run_rows("clr then acc", 12, 14);
    run_random();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : ppu_tb

`default_nettype wire

// ==== ppu_top.sv ====
`default_nettype none

// pipelined processing unit
// one op per clock, result PIPE_DEPTH cycles later
module ppu_top (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  wire                  valid_i,
  input  wire ppu_pkg::operation_e op_i,
  input  wire ppu_pkg::operand_t   a_i,
  input  wire ppu_pkg::operand_t   b_i,
  output logic                 stall_o,
  output logic                 valid_o,
  output ppu_pkg::result_t     result_o
);

  // op taken this cycle
  wire accept;
  // ACC or CLR result retiring this cycle
  wire acc_we;

  ppu_control_unit u_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .accept_o (accept),
    .valid_o  (valid_o),
    .acc_we_o (acc_we),
    .stall_o  (stall_o)
  );

  // producer holds op and operands while stalled
  ppu_datapath u_dp (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .accept_i (accept),
    .acc_we_i (acc_we),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .result_o (result_o)
  );

endmodule : ppu_top

`default_nettype wire

// ==== vlog.f ====
ppu_pkg.sv
pipeline.sv
ppu_control_unit.sv
ppu_datapath.sv
ppu_top.sv
ppu_tb.sv
